// ==== Makefile ====
# Verilator build and run for the data-memory stage testbench
# Any variable can be overridden, e.g. make run TOP=tb_lsu_mem OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_lsu_mem
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
PASS_MSG  ?= Verification passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Status comes from the search for the pass line in the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_clkgen.sv ====
/*
  Testbench clock and reset source
  40 ns clock, rst_n low for the first 3 cycles
*/
module tb_clkgen
(
   output logic CLK,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int PERIOD  = 40;   // ns
   localparam int RST_CYC = 3;

   initial
   begin
      CLK = 1'b0;
      forever #(PERIOD / 2) CLK = ~CLK;
   end

   initial
   begin
      rst_n = 1'b0;                  // Asserted from time 0
      repeat (RST_CYC) @(posedge CLK);
      rst_n <= 1'b1;
   end

endmodule

// ==== dv/tb_lsu_mem.sv ====
/*
  Testbench for the data-memory stage
  Random requests checked against a byte-array model, in order
*/
module tb_lsu_mem;
   timeunit 1ns;
   timeprecision 100ps;

   import lsu_pkg::*;

   localparam int CLK_NS    = 40;
   localparam int RST_CYC   = 3;
   localparam int MEM_BYTES = 1 << ADDR_W;
   localparam int N_WORDS   = SRAM_DEPTH;
   localparam int N_PART    = 64;    // Store plus readback pairs
   localparam int N_EXT     = 200;
   localparam int N_MIS     = 48;    // Misaligned plus readback pairs
   localparam int N_MIX     = 400;
   localparam int N_REQ     = 2 + 2 * N_WORDS + 2 * N_PART + N_EXT + 2 * N_MIS + N_MIX;

   // One outstanding response
   typedef struct packed
   {
      data_t       data;
      logic        err;
      logic [31:0] stamp;   // Cycle in which the strobe was visible
   } exp_t;

   logic  CLK;
   logic  rst_n;
   logic  req_valid;
   logic  req_we;
   addr_t req_addr;
   size_e req_size;
   logic  req_signed;
   data_t req_wdata;
   logic  resp_valid;
   data_t resp_data;
   logic  resp_err;

   logic [7:0] model [MEM_BYTES];   // Reference byte memory
   exp_t       exp_q [$];
   integer     seed      = 32'h31b6_2a46;
   int         cyc       = 0;        // Falling edges seen
   int         errors    = 0;
   int         checks    = 0;
   int         n_tests   = 0;
   int         test_err0 = 0;

   tb_clkgen u_clkgen
   (
      .CLK   (CLK),
      .rst_n (rst_n)
   );

   lsu_mem_top u_dut
   (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req_we     (req_we),
      .req_addr   (req_addr),
      .req_size   (req_size),
      .req_signed (req_signed),
      .req_wdata  (req_wdata),
      .resp_valid (resp_valid),
      .resp_data  (resp_data),
      .resp_err   (resp_err)
   );

   function automatic logic [31:0] rand_bits();
      rand_bits = $random(seed);
   endfunction

   task automatic check_val(input string name, input logic [63:0] exp_v,
                            input logic [63:0] act_v);
      checks++;
      if (act_v !== exp_v)
      begin
         errors++;
         $display("error: time %0t signal %s expected %h actual %h",
                  $time, name, exp_v, act_v);
      end
   endtask

   // Drive one request and queue its expected response
   task automatic issue(input logic st, input addr_t addr, input size_e size,
                        input logic sgn, input data_t wdata);
      int    nb;
      exp_t  e;
      data_t v;
      @(posedge CLK);
      nb      = 1 << int'(size);
      v       = '0;
      e.err   = ((int'(addr) % nb) != 0);   // Natural alignment rule
      e.data  = '0;                         // Stores and errors answer zero
      e.stamp = 32'(cyc + 1);
      if (!e.err)
      begin
         for (int i = 0; i < nb; i++)
         begin
            if (st)
               model[int'(addr) + i] = wdata[8*i +: 8];   // Little endian
            else
               v[8*i +: 8] = model[int'(addr) + i];
         end
         if (!st)
         begin
            if (sgn && v[8*nb-1])
            begin
               for (int i = nb; i < BYTES_W; i++)
                  v[8*i +: 8] = 8'hff;
            end
            e.data = v;
         end
      end
      req_valid  <= 1'b1;
      req_we     <= st;
      req_addr   <= addr;
      req_size   <= size;
      req_signed <= sgn;
      req_wdata  <= wdata;
      exp_q.push_back(e);
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(posedge CLK);
         req_valid <= 1'b0;
      end
   endtask

   // Wait out the pipeline, then report the test
   task automatic end_test(input string name, input int n_req);
      int waited;
      waited = 0;
      idle(1);
      while (exp_q.size() != 0 && waited < 8)
      begin
         @(posedge CLK);
         waited++;
      end
      if (exp_q.size() != 0)
      begin
         errors++;
         $display("%0d responses never arrived in test %s", exp_q.size(), name);
         exp_q.delete();
      end
      n_tests++;
      $display("Test %0d %s: %0d requests, %0d errors", n_tests, name, n_req,
               errors - test_err0);
      test_err0 = errors;
   endtask

   // Response monitor, samples mid-cycle
   always @(negedge CLK)
   begin : monitor
      exp_t e;
      cyc = cyc + 1;
      if (resp_valid === 1'b1)
      begin
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("Response at time %0t with no request outstanding", $time);
         end
         else
         begin
            e = exp_q.pop_front();
            check_val("resp_err", 64'(e.err), 64'(resp_err));
            check_val("resp_data", e.data, resp_data);
            check_val("resp_latency", 64'(2), 64'(cyc - int'(e.stamp)));   // Fixed at 2
         end
      end
      else if (exp_q.size() != 0 && cyc >= int'(exp_q[0].stamp) + 2)
      begin
         errors++;
         $display("Response missing at time %0t for request of cycle %0d",
                  $time, exp_q[0].stamp);
         void'(exp_q.pop_front());
      end
   end

   // Watchdog sized from the request count
   initial
   begin
      #(N_REQ * CLK_NS * 4 + RST_CYC * CLK_NS);
      $display("Watchdog expired at time %0t, simulation stuck", $time);
      $display("Verification failed");
      $finish;
   end

   initial
   begin : main
      logic [31:0] r;
      addr_t       a;
      size_e       s;
      int          nb;
      int          mix_cnt;
      req_valid  = 1'b0;
      req_we     = 1'b0;
      req_addr   = '0;
      req_size   = SZ_B;
      req_signed = 1'b0;
      req_wdata  = '0;
      for (int i = 0; i < MEM_BYTES; i++)
         model[i] = 8'h00;

      // 1. Reset and first request
      while (rst_n !== 1'b1)
      begin
         @(negedge CLK);
         check_val("resp_valid", 64'(0), 64'(resp_valid));
      end
      repeat (4)
      begin
         @(negedge CLK);
         check_val("resp_valid", 64'(0), 64'(resp_valid));   // Nothing issued yet
      end
      issue(1'b1, addr_t'(0), SZ_D, 1'b0, {rand_bits(), rand_bits()});
      issue(1'b0, addr_t'(0), SZ_D, 1'b0, '0);
      end_test("reset", 2);

      // 2. Fill then read every word, back to back
      for (int w = 0; w < N_WORDS; w++)
         issue(1'b1, addr_t'(w * BYTES_W), SZ_D, 1'b0, {rand_bits(), rand_bits()});
      for (int w = 0; w < N_WORDS; w++)
         issue(1'b0, addr_t'(w * BYTES_W), SZ_D, 1'b0, '0);
      end_test("fill_readback", 2 * N_WORDS);

      // 3. Byte, half and word stores, each checked by a full-word load
      for (int k = 0; k < N_PART; k++)
      begin
         r  = rand_bits();
         s  = size_e'(2'(r[7:0] % 3));
         nb = 1 << int'(s);
         a  = addr_t'(rand_bits()) & ~addr_t'(nb - 1);
         issue(1'b1, a, s, 1'b0, {rand_bits(), rand_bits()});
         issue(1'b0, a & ~addr_t'(BYTES_W - 1), SZ_D, 1'b0, '0);   // Neighbours too
      end
      end_test("partial_store", 2 * N_PART);

      // 4. Loads of every size, signed and unsigned
      for (int k = 0; k < N_EXT; k++)
      begin
         r  = rand_bits();
         s  = size_e'(2'(k % 4));
         nb = 1 << int'(s);
         a  = addr_t'(rand_bits()) & ~addr_t'(nb - 1);
         issue(1'b0, a, s, r[0], '0);
      end
      end_test("extension", N_EXT);

      // 5. Misaligned requests leave memory alone
      for (int k = 0; k < N_MIS; k++)
      begin
         r  = rand_bits();
         s  = size_e'(2'(1 + r[7:0] % 3));   // Half and up
         nb = 1 << int'(s);
         a  = addr_t'(rand_bits()) | addr_t'(1 + rand_bits() % (nb - 1));
         issue(r[8], a, s, r[9], {rand_bits(), rand_bits()});
         issue(1'b0, a & ~addr_t'(BYTES_W - 1), SZ_D, 1'b0, '0);
      end
      end_test("misalign", 2 * N_MIS);

      // 6. Mixed stream with random gaps
      mix_cnt = 0;
      while (mix_cnt < N_MIX)
      begin
         r  = rand_bits();
         s  = size_e'(r[1:0]);
         nb = 1 << int'(s);
         a  = addr_t'(rand_bits());
         if (r[7:4] != 4'd0)
            a = a & ~addr_t'(nb - 1);   // Mostly aligned
         if (r[10:8] == 3'd0)
         begin
            issue(1'b1, a, s, r[2], {rand_bits(), rand_bits()});
            issue(1'b0, a, s, r[3], '0);   // Load right behind the store
            mix_cnt += 2;
         end
         else
         begin
            issue(r[11], a, s, r[2], {rand_bits(), rand_bits()});
            mix_cnt++;
         end
         idle(int'(r[13:12]));
      end
      end_test("mixed", mix_cnt);

      $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, checks, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// ==== hdl/lsu_load_extract.sv ====
/*
  Stage 3 of the data-memory pipeline
  Lane select and sign or zero extension of load data
*/
module lsu_load_extract
(
   input  logic           CLK,
   input  logic           rst_n,
   input  logic           s1_valid,
   input  logic           s1_load,     // 0 = store response
   input  logic           s1_err,      // Misaligned request
   input  lsu_pkg::size_e s1_size,
   input  logic           s1_signed,
   input  lsu_pkg::ofs_t  s1_ofs,
   input  lsu_pkg::data_t sram_dout,   // Row read in stage 2
   output logic           resp_valid,
   output lsu_pkg::data_t resp_data,
   output logic           resp_err
);
   import lsu_pkg::*;

   data_t shifted;    // Addressed byte moved to lane 0
   data_t ext_data;   // Extended load value
   logic  ret_data;   // Response carries load data

   // Offset in bytes, scaled to bits
   assign shifted = sram_dout >> {s1_ofs, 3'b000};

   // Keep access-size bytes, fill upper bits
   always_comb
   begin
      ext_data = shifted;
      case (s1_size)
         SZ_B:
            ext_data = {{DATA_W-8{s1_signed & shifted[7]}}, shifted[7:0]};
         SZ_H:
            ext_data = {{DATA_W-16{s1_signed & shifted[15]}}, shifted[15:0]};
         SZ_W:
            ext_data = {{DATA_W-32{s1_signed & shifted[31]}}, shifted[31:0]};
         SZ_D:
            ext_data = shifted;   // Full word, nothing to extend
         default:
            ext_data = shifted;
      endcase
   end

   // Only good loads return data
   assign ret_data = s1_valid & s1_load & ~s1_err;

   /*
     Response register, two clocks after the request strobe;
     stores and errors answer with zero data
   */
   always_ff @(posedge CLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         resp_valid <= 1'b0;
         resp_err   <= 1'b0;
         resp_data  <= '0;
      end
      else
      begin
         resp_valid <= s1_valid;
         resp_err   <= s1_valid & s1_err;
         resp_data  <= ret_data ? ext_data : '0;
      end
   end

endmodule

// ==== hdl/lsu_mem_top.sv ====
/*
  Data-memory stage top level
  Align, SRAM and load-extract pipeline, fixed latency of 2
*/
module lsu_mem_top
(
   input  logic           CLK,
   input  logic           rst_n,
   input  logic           req_valid,
   input  logic           req_we,
   input  lsu_pkg::addr_t req_addr,
   input  lsu_pkg::size_e req_size,
   input  logic           req_signed,
   input  lsu_pkg::data_t req_wdata,
   output logic           resp_valid,
   output lsu_pkg::data_t resp_data,
   output logic           resp_err
);
   import lsu_pkg::*;

   // Stage 1 to SRAM
   word_addr_t sram_addr;
   logic       sram_re;
   bmask_t     sram_we;
   data_t      sram_din;
   data_t      sram_dout;   // SRAM to stage 3

   // Stage 1 to stage 3 sideband
   logic  s1_valid;
   logic  s1_load;
   logic  s1_err;
   size_e s1_size;
   logic  s1_signed;
   ofs_t  s1_ofs;

   lsu_req_align u_align
   (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req_we     (req_we),
      .req_addr   (req_addr),
      .req_size   (req_size),
      .req_signed (req_signed),
      .req_wdata  (req_wdata),
      .sram_addr  (sram_addr),
      .sram_re    (sram_re),
      .sram_we    (sram_we),
      .sram_din   (sram_din),
      .s1_valid   (s1_valid),
      .s1_load    (s1_load),
      .s1_err     (s1_err),
      .s1_size    (s1_size),
      .s1_signed  (s1_signed),
      .s1_ofs     (s1_ofs)
   );

   sram_sp_be u_sram
   (
      .CLK  (CLK),
      .addr (sram_addr),
      .re   (sram_re),
      .we   (sram_we),
      .din  (sram_din),
      .dout (sram_dout)
   );

   lsu_load_extract u_extract
   (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .s1_valid   (s1_valid),
      .s1_load    (s1_load),
      .s1_err     (s1_err),
      .s1_size    (s1_size),
      .s1_signed  (s1_signed),
      .s1_ofs     (s1_ofs),
      .sram_dout  (sram_dout),
      .resp_valid (resp_valid),
      .resp_data  (resp_data),
      .resp_err   (resp_err)
   );

endmodule

// ==== hdl/lsu_pkg.sv ====
/*
  Load/store memory stage package
  Width constants, vector types and access-size encoding
*/
package lsu_pkg;

   localparam int DATA_W  = 64;                // One CPU word
   localparam int BYTE_W  = 8;
   localparam int BYTES_W = DATA_W / BYTE_W;   // Byte lanes per word
   localparam int OFS_W   = $clog2(BYTES_W);   // Byte offset within word
   localparam int ADDR_W  = 12;                // 4 KiB data space
   localparam int WORD_AW = ADDR_W - OFS_W;    // SRAM row address

   // SRAM geometry
   localparam int SRAM_DEPTH = 1 << WORD_AW;

   typedef logic [DATA_W-1:0]  data_t;         // Load or store data
   typedef logic [ADDR_W-1:0]  addr_t;         // Byte address
   typedef logic [WORD_AW-1:0] word_addr_t;    // SRAM row
   typedef logic [BYTES_W-1:0] bmask_t;        // Byte write enables
   typedef logic [OFS_W-1:0]   ofs_t;          // Byte offset

   // Read data seen right after a write edge, as on a hard macro
   localparam data_t SRAM_X_PAT = {DATA_W/2{2'b01}};

   // Access size, log2 of byte count
   typedef enum logic [1:0]
   {
      SZ_B = 2'd0,   // 1 byte
      SZ_H = 2'd1,   // 2 bytes
      SZ_W = 2'd2,   // 4 bytes
      SZ_D = 2'd3    // 8 bytes
   } size_e;

endpackage

// ==== hdl/lsu_req_align.sv ====
/*
  Stage 1 of the data-memory pipeline
  Alignment check, byte mask and lane replication, SRAM drive
*/
module lsu_req_align
(
   input  logic                CLK,
   input  logic                rst_n,
   input  logic                req_valid,   // One-cycle strobe
   input  logic                req_we,      // 1 = store
   input  lsu_pkg::addr_t      req_addr,
   input  lsu_pkg::size_e      req_size,
   input  logic                req_signed,
   input  lsu_pkg::data_t      req_wdata,
   output lsu_pkg::word_addr_t sram_addr,
   output logic                sram_re,
   output lsu_pkg::bmask_t     sram_we,
   output lsu_pkg::data_t      sram_din,
   output logic                s1_valid,
   output logic                s1_load,
   output logic                s1_err,
   output lsu_pkg::size_e      s1_size,
   output logic                s1_signed,
   output lsu_pkg::ofs_t       s1_ofs
);
   import lsu_pkg::*;

   ofs_t   ofs;         // Byte offset in word
   logic   misalign;    // Offset not a multiple of size
   bmask_t size_mask;   // Lanes touched at offset 0
   logic   go_ok;       // Valid and aligned

   assign ofs       = req_addr[OFS_W-1:0];
   assign sram_addr = req_addr[ADDR_W-1:OFS_W];

   // Per-size alignment, mask and store data replication
   always_comb
   begin
      misalign  = 1'b0;
      size_mask = '1;
      sram_din  = req_wdata;
      case (req_size)
         SZ_B:
         begin
            size_mask = 8'h01;
            sram_din  = {BYTES_W{req_wdata[7:0]}};   // Any byte lane
         end
         SZ_H:
         begin
            misalign  = ofs[0];
            size_mask = 8'h03;
            sram_din  = {BYTES_W/2{req_wdata[15:0]}};
         end
         SZ_W:
         begin
            misalign  = |ofs[1:0];
            size_mask = 8'h0f;
            sram_din  = {BYTES_W/4{req_wdata[31:0]}};
         end
         SZ_D:
         begin
            misalign  = |ofs;   // Whole word only at offset 0
            size_mask = 8'hff;
            sram_din  = req_wdata;
         end
         default:
         begin
            misalign  = 1'b1;
         end
      endcase
   end

   assign go_ok   = req_valid & ~misalign;
   assign sram_re = go_ok & ~req_we;                           // Loads read
   assign sram_we = (go_ok & req_we) ? (size_mask << ofs) : '0; // Stores write lanes

   // Pipeline valid
   always_ff @(posedge CLK or negedge rst_n)
   begin
      if (!rst_n)
         s1_valid <= 1'b0;
      else
         s1_valid <= req_valid;
   end

   // Sideband for stage 3, captured on strobe
   always_ff @(posedge CLK)
   begin
      if (req_valid)
      begin
         s1_load   <= ~req_we;
         s1_err    <= misalign;
         s1_size   <= req_size;
         s1_signed <= req_signed;
         s1_ofs    <= ofs;
      end
   end

endmodule

// ==== hdl/sram_sp_be.sv ====
/*
  Single-port SRAM model with byte write enables
  Registered read; read data undefined in the cycle after a write
*/
module sram_sp_be
(
   input  logic                CLK,
   input  lsu_pkg::word_addr_t addr,   // Row address
   input  logic                re,     // Read strobe
   input  lsu_pkg::bmask_t     we,     // Per-byte write enables
   input  lsu_pkg::data_t      din,
   output lsu_pkg::data_t      dout
);
   import lsu_pkg::*;

   data_t mem [SRAM_DEPTH];   // Storage array
   data_t rdat_q;             // Read data register
   logic  wr_q;               // Previous edge was a write

   // Read port, holds value when idle
   always_ff @(posedge CLK)
   begin
      if (re)
         rdat_q <= mem[addr];
   end

   // Byte lane writes
   always_ff @(posedge CLK)
   begin
      for (int b = 0; b < BYTES_W; b++)
      begin
         if (we[b])
            mem[addr][b*BYTE_W +: BYTE_W] <= din[b*BYTE_W +: BYTE_W];
      end
   end

   // Track write activity for output corruption
   always_ff @(posedge CLK)
   begin
      wr_q <= |we;
   end

   /*
     A real macro drives garbage on Q after a write cycle,
     so the model shows a fixed pattern there instead
   */
   assign dout = wr_q ? SRAM_X_PAT : rdat_q;

endmodule

// ==== vlog.f ====
hdl/lsu_pkg.sv
hdl/sram_sp_be.sv
hdl/lsu_req_align.sv
hdl/lsu_load_extract.sv
hdl/lsu_mem_top.sv
dv/tb_clkgen.sv
dv/tb_lsu_mem.sv
